//--- Bender.yml
package:
  name: core_mem

export_include_dirs:
  - include

sources:
  - rtl/core_mem_pkg.sv
  - rtl/result_hold.sv
  - rtl/fetch_unit.sv
  - rtl/clint_timer.sv
  - rtl/load_store_unit.sv
  - rtl/bus_arbiter.sv
  - rtl/core_mem_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/core_mem_assertions.sv
      - testbench/core_mem_tb.sv

//--- files.f
+incdir+include
rtl/core_mem_pkg.sv
rtl/result_hold.sv
rtl/fetch_unit.sv
rtl/clint_timer.sv
rtl/load_store_unit.sv
rtl/bus_arbiter.sv
rtl/core_mem_top.sv
testbench/tb_clock_gen.sv
testbench/core_mem_assertions.sv
testbench/core_mem_tb.sv

//--- include/core_mem_consts.svh
`ifndef CORE_MEM_CONSTS_SVH
`define CORE_MEM_CONSTS_SVH

`define CM_XLEN 64
`define CM_INS_W 32

// first fetch after reset
`define CM_RESET_PC 64'h0000_0000_8000_0000

// clint registers, decoded inside the lsu
`define CM_MTIMECMP_ADDR 64'h0000_0000_0200_4000
`define CM_MTIME_ADDR 64'h0000_0000_0200_bff8

// bus transaction ids
`define CM_ID_FETCH 1'b0
`define CM_ID_MEM 1'b1

`endif

//--- rtl/bus_arbiter.sv
`timescale 1ns/1ps
`include "core_mem_consts.svh"

module bus_arbiter (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    i_fetch_req_valid,
	input  core_mem_pkg::xlen_t     i_fetch_req_addr,
	output logic                    o_fetch_resp_valid,
	output core_mem_pkg::xlen_t     o_fetch_resp_data,
	input  logic                    i_mem_req_valid,
	input  core_mem_pkg::xlen_t     i_mem_req_addr,
	input  core_mem_pkg::bus_size_t i_mem_req_size,
	input  logic                    i_mem_req_write,
	input  core_mem_pkg::xlen_t     i_mem_req_wdata,
	input  core_mem_pkg::wmask_t    i_mem_req_wmask,
	output logic                    o_mem_resp_valid,
	output core_mem_pkg::xlen_t     o_mem_resp_data,
	output logic                    o_bus_valid,
	input  logic                    i_bus_ready,
	output core_mem_pkg::xlen_t     o_bus_addr,
	output core_mem_pkg::bus_size_t o_bus_size,
	output logic                    o_bus_write,
	output core_mem_pkg::xlen_t     o_bus_wdata,
	output core_mem_pkg::wmask_t    o_bus_wmask,
	output logic                    o_bus_id,
	input  core_mem_pkg::xlen_t     i_bus_rdata,
	input  logic                    i_bus_ret_id
);

	logic grant;

	// only grant when nothing is outstanding
	assign grant = !o_bus_valid && (i_mem_req_valid || i_fetch_req_valid);

	always_ff @(posedge clock) begin
		if (reset) begin
			o_bus_valid <= 1'b0;
		end else if (grant) begin
			o_bus_valid <= 1'b1;
		end else if (i_bus_ready) begin
			o_bus_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (grant) begin
			if (i_mem_req_valid) begin // memory first
				o_bus_addr <= i_mem_req_addr;
				o_bus_size <= i_mem_req_size;
				o_bus_write <= i_mem_req_write;
				o_bus_wdata <= i_mem_req_wdata;
				o_bus_wmask <= i_mem_req_wmask;
				o_bus_id <= `CM_ID_MEM;
			end else begin
				o_bus_addr <= i_fetch_req_addr;
				o_bus_size <= core_mem_pkg::SIZE_WORD;
				o_bus_write <= 1'b0;
				o_bus_wdata <= '0;
				o_bus_wmask <= '0;
				o_bus_id <= `CM_ID_FETCH;
			end
		end
	end

	assign o_fetch_resp_valid = o_bus_valid && i_bus_ready && (i_bus_ret_id == `CM_ID_FETCH);
	assign o_mem_resp_valid = o_bus_valid && i_bus_ready && (i_bus_ret_id == `CM_ID_MEM);
	assign o_fetch_resp_data = i_bus_rdata;
	assign o_mem_resp_data = i_bus_rdata;

endmodule

//--- rtl/clint_timer.sv
`timescale 1ns/1ps

module clint_timer (
	input  logic                clock,
	input  logic                reset,
	input  logic                i_wen_mtime,
	input  logic                i_wen_mtimecmp,
	input  core_mem_pkg::xlen_t i_wdata,
	output core_mem_pkg::xlen_t o_mtime,
	output core_mem_pkg::xlen_t o_mtimecmp,
	output logic                o_timer_irq
);

	always_ff @(posedge clock) begin
		if (reset) begin
			o_mtime <= '0;
		end else if (i_wen_mtime) begin
			o_mtime <= i_wdata;
		end else begin
			o_mtime <= o_mtime + 1'b1;
		end
	end

	// all ones keeps the interrupt quiet until software sets a compare
	always_ff @(posedge clock) begin
		if (reset) begin
			o_mtimecmp <= '1;
		end else if (i_wen_mtimecmp) begin
			o_mtimecmp <= i_wdata;
		end
	end

	assign o_timer_irq = (o_mtime >= o_mtimecmp);

endmodule

//--- rtl/core_mem_pkg.sv
`include "core_mem_consts.svh"

package core_mem_pkg;

	typedef logic [`CM_XLEN-1:0] xlen_t;
	typedef logic [`CM_INS_W-1:0] instr_t;

	typedef enum logic [1:0] {
		SIZE_BYTE   = 2'd0,
		SIZE_HALF   = 2'd1,
		SIZE_WORD   = 2'd2,
		SIZE_DOUBLE = 2'd3
	} bus_size_t;

	// low two bits are the size, bit 2 set means unsigned load
	typedef logic [2:0] ls_func3_t;

	typedef logic [7:0] wmask_t;

	typedef struct packed {
		xlen_t  pc;
		instr_t instr;
	} fetch_packet_t;

endpackage

//--- rtl/core_mem_top.sv
`timescale 1ns/1ps

module core_mem_top (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    i_redirect,
	input  core_mem_pkg::xlen_t     i_redirect_pc,
	output logic                    o_fetch_valid,
	output core_mem_pkg::xlen_t     o_fetch_pc,
	output core_mem_pkg::instr_t    o_fetch_instr,
	input  logic                    i_fetch_ready,
	input  logic                    i_ls_valid,
	output logic                    o_ls_ready,
	input  core_mem_pkg::xlen_t     i_ls_addr,
	input  core_mem_pkg::xlen_t     i_ls_wdata,
	input  core_mem_pkg::ls_func3_t i_ls_func3,
	input  logic                    i_ls_load,
	input  logic                    i_ls_store,
	output logic                    o_ls_done_valid,
	output core_mem_pkg::xlen_t     o_ls_rdata,
	input  logic                    i_ls_done_ready,
	output logic                    o_bus_valid,
	input  logic                    i_bus_ready,
	output core_mem_pkg::xlen_t     o_bus_addr,
	output core_mem_pkg::bus_size_t o_bus_size,
	output logic                    o_bus_write,
	output core_mem_pkg::xlen_t     o_bus_wdata,
	output core_mem_pkg::wmask_t    o_bus_wmask,
	output logic                    o_bus_id,
	input  core_mem_pkg::xlen_t     i_bus_rdata,
	input  logic                    i_bus_ret_id,
	output logic                    o_timer_irq
);

	logic fetch_req_valid;
	core_mem_pkg::xlen_t fetch_req_addr;
	logic fetch_resp_valid;
	core_mem_pkg::xlen_t fetch_resp_data;
	logic mem_req_valid;
	core_mem_pkg::xlen_t mem_req_addr;
	core_mem_pkg::bus_size_t mem_req_size;
	logic mem_req_write;
	core_mem_pkg::xlen_t mem_req_wdata;
	core_mem_pkg::wmask_t mem_req_wmask;
	logic mem_resp_valid;
	core_mem_pkg::xlen_t mem_resp_data;

	fetch_unit fetch_unit_i (
		.clock         (clock),
		.reset         (reset),
		.i_redirect    (i_redirect),
		.i_redirect_pc (i_redirect_pc),
		.o_req_valid   (fetch_req_valid),
		.o_req_addr    (fetch_req_addr),
		.i_resp_valid  (fetch_resp_valid),
		.i_resp_data   (fetch_resp_data),
		.o_fetch_valid (o_fetch_valid),
		.o_fetch_pc    (o_fetch_pc),
		.o_fetch_instr (o_fetch_instr),
		.i_fetch_ready (i_fetch_ready)
	);

	load_store_unit load_store_unit_i (
		.clock           (clock),
		.reset           (reset),
		.i_ls_valid      (i_ls_valid),
		.o_ls_ready      (o_ls_ready),
		.i_ls_addr       (i_ls_addr),
		.i_ls_wdata      (i_ls_wdata),
		.i_ls_func3      (i_ls_func3),
		.i_ls_load       (i_ls_load),
		.i_ls_store      (i_ls_store),
		.o_ls_done_valid (o_ls_done_valid),
		.o_ls_rdata      (o_ls_rdata),
		.i_ls_done_ready (i_ls_done_ready),
		.o_req_valid     (mem_req_valid),
		.o_req_addr      (mem_req_addr),
		.o_req_size      (mem_req_size),
		.o_req_write     (mem_req_write),
		.o_req_wdata     (mem_req_wdata),
		.o_req_wmask     (mem_req_wmask),
		.i_resp_valid    (mem_resp_valid),
		.i_resp_data     (mem_resp_data),
		.o_timer_irq     (o_timer_irq)
	);

	bus_arbiter bus_arbiter_i (
		.clock              (clock),
		.reset              (reset),
		.i_fetch_req_valid  (fetch_req_valid),
		.i_fetch_req_addr   (fetch_req_addr),
		.o_fetch_resp_valid (fetch_resp_valid),
		.o_fetch_resp_data  (fetch_resp_data),
		.i_mem_req_valid    (mem_req_valid),
		.i_mem_req_addr     (mem_req_addr),
		.i_mem_req_size     (mem_req_size),
		.i_mem_req_write    (mem_req_write),
		.i_mem_req_wdata    (mem_req_wdata),
		.i_mem_req_wmask    (mem_req_wmask),
		.o_mem_resp_valid   (mem_resp_valid),
		.o_mem_resp_data    (mem_resp_data),
		.o_bus_valid        (o_bus_valid),
		.i_bus_ready        (i_bus_ready),
		.o_bus_addr         (o_bus_addr),
		.o_bus_size         (o_bus_size),
		.o_bus_write        (o_bus_write),
		.o_bus_wdata        (o_bus_wdata),
		.o_bus_wmask        (o_bus_wmask),
		.o_bus_id           (o_bus_id),
		.i_bus_rdata        (i_bus_rdata),
		.i_bus_ret_id       (i_bus_ret_id)
	);

endmodule

//--- rtl/fetch_unit.sv
`timescale 1ns/1ps
`include "core_mem_consts.svh"

module fetch_unit (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 i_redirect,
	input  core_mem_pkg::xlen_t  i_redirect_pc,
	output logic                 o_req_valid,
	output core_mem_pkg::xlen_t  o_req_addr,
	input  logic                 i_resp_valid,
	input  core_mem_pkg::xlen_t  i_resp_data,
	output logic                 o_fetch_valid,
	output core_mem_pkg::xlen_t  o_fetch_pc,
	output core_mem_pkg::instr_t o_fetch_instr,
	input  logic                 i_fetch_ready
);

	core_mem_pkg::xlen_t pc_q;
	logic discard_q;
	logic accept;
	logic hold_load;
	logic hold_ready;
	core_mem_pkg::fetch_packet_t resp_pkt;
	core_mem_pkg::fetch_packet_t held_pkt;

	assign accept = o_fetch_valid && i_fetch_ready;
	assign hold_ready = i_fetch_ready || i_redirect; // redirect drops a stale packet
	assign hold_load = i_resp_valid && !discard_q && !i_redirect;

	assign resp_pkt.pc = pc_q;
	assign resp_pkt.instr = pc_q[2] ? i_resp_data[`CM_XLEN-1:`CM_INS_W]
		: i_resp_data[`CM_INS_W-1:0];

	// bus works on doublewords, pc bit 2 picks the half
	assign o_req_addr = {pc_q[`CM_XLEN-1:3], 3'b000};

	always_ff @(posedge clock) begin
		if (reset) begin
			pc_q <= `CM_RESET_PC;
		end else if (i_redirect) begin
			pc_q <= i_redirect_pc;
		end else if (accept) begin
			pc_q <= pc_q + 4;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			o_req_valid <= 1'b0;
			discard_q <= 1'b0;
		end else if (i_resp_valid) begin
			o_req_valid <= 1'b0;
			discard_q <= 1'b0;
		end else if (o_req_valid) begin
			if (i_redirect) begin
				discard_q <= 1'b1; // in-flight word belongs to the old path
			end
		end else if (!o_fetch_valid || hold_ready) begin
			o_req_valid <= 1'b1;
		end
	end

	result_hold #(
		.payload_t(core_mem_pkg::fetch_packet_t)
	) fetch_hold_i (
		.i_clock (clock),
		.i_reset (reset),
		.i_load  (hold_load),
		.i_data  (resp_pkt),
		.o_valid (o_fetch_valid),
		.o_data  (held_pkt),
		.i_ready (hold_ready)
	);

	assign o_fetch_pc = held_pkt.pc;
	assign o_fetch_instr = held_pkt.instr;

endmodule

//--- rtl/load_store_unit.sv
`timescale 1ns/1ps
`include "core_mem_consts.svh"

module load_store_unit (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   i_ls_valid,
	output logic                   o_ls_ready,
	input  core_mem_pkg::xlen_t    i_ls_addr,
	input  core_mem_pkg::xlen_t    i_ls_wdata,
	input  core_mem_pkg::ls_func3_t i_ls_func3,
	input  logic                   i_ls_load,
	input  logic                   i_ls_store,
	output logic                   o_ls_done_valid,
	output core_mem_pkg::xlen_t    o_ls_rdata,
	input  logic                   i_ls_done_ready,
	output logic                   o_req_valid,
	output core_mem_pkg::xlen_t    o_req_addr,
	output core_mem_pkg::bus_size_t o_req_size,
	output logic                   o_req_write,
	output core_mem_pkg::xlen_t    o_req_wdata,
	output core_mem_pkg::wmask_t   o_req_wmask,
	input  logic                   i_resp_valid,
	input  core_mem_pkg::xlen_t    i_resp_data,
	output logic                   o_timer_irq
);

	logic busy_q;
	logic timer_q;
	logic sel_mtime_q;
	logic store_q;
	logic zext_q;
	logic [2:0] off_q;
	logic take;
	logic done_load;
	logic is_timer_addr;
	core_mem_pkg::bus_size_t size_in;
	core_mem_pkg::wmask_t mask_in;
	core_mem_pkg::xlen_t mtime;
	core_mem_pkg::xlen_t mtimecmp;
	core_mem_pkg::xlen_t raw_data;
	core_mem_pkg::xlen_t shifted;
	core_mem_pkg::xlen_t load_data;
	core_mem_pkg::xlen_t result;

	assign o_ls_ready = !busy_q && !o_ls_done_valid;
	assign take = i_ls_valid && o_ls_ready && (i_ls_load || i_ls_store);
	assign size_in = core_mem_pkg::bus_size_t'(i_ls_func3[1:0]);
	assign is_timer_addr = (i_ls_addr == `CM_MTIMECMP_ADDR) || (i_ls_addr == `CM_MTIME_ADDR);

	always_comb begin
		case (size_in)
			core_mem_pkg::SIZE_BYTE: mask_in = 8'h01 << i_ls_addr[2:0];
			core_mem_pkg::SIZE_HALF: mask_in = 8'h03 << i_ls_addr[2:0];
			core_mem_pkg::SIZE_WORD: mask_in = 8'h0f << i_ls_addr[2:0];
			default: mask_in = 8'hff;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			busy_q <= 1'b0;
		end else if (take) begin
			busy_q <= 1'b1;
		end else if (done_load) begin
			busy_q <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			timer_q <= is_timer_addr;
			sel_mtime_q <= (i_ls_addr == `CM_MTIME_ADDR);
			store_q <= i_ls_store;
			zext_q <= i_ls_func3[2];
			off_q <= i_ls_addr[2:0];
			o_req_addr <= {i_ls_addr[`CM_XLEN-1:3], 3'b000};
			o_req_size <= size_in;
			o_req_wdata <= i_ls_wdata << {i_ls_addr[2:0], 3'b000}; // into byte lanes
			o_req_wmask <= i_ls_store ? mask_in : '0;
		end
	end

	assign o_req_valid = busy_q && !timer_q; // timer never reaches the bus
	assign o_req_write = store_q;
	assign done_load = busy_q && (timer_q || i_resp_valid);

	clint_timer clint_timer_i (
		.clock          (clock),
		.reset          (reset),
		.i_wen_mtime    (busy_q && timer_q && store_q && sel_mtime_q),
		.i_wen_mtimecmp (busy_q && timer_q && store_q && !sel_mtime_q),
		.i_wdata        (o_req_wdata),
		.o_mtime        (mtime),
		.o_mtimecmp     (mtimecmp),
		.o_timer_irq    (o_timer_irq)
	);

	assign raw_data = timer_q ? (sel_mtime_q ? mtime : mtimecmp) : i_resp_data;
	assign shifted = raw_data >> {off_q, 3'b000};

	always_comb begin
		case (o_req_size)
			core_mem_pkg::SIZE_BYTE:
				load_data = {{(`CM_XLEN-8){~zext_q & shifted[7]}}, shifted[7:0]};
			core_mem_pkg::SIZE_HALF:
				load_data = {{(`CM_XLEN-16){~zext_q & shifted[15]}}, shifted[15:0]};
			core_mem_pkg::SIZE_WORD:
				load_data = {{(`CM_XLEN-32){~zext_q & shifted[31]}}, shifted[31:0]};
			default: load_data = shifted;
		endcase
	end

	assign result = store_q ? '0 : load_data; // stores report zero

	result_hold #(
		.payload_t(core_mem_pkg::xlen_t)
	) ls_hold_i (
		.i_clock (clock),
		.i_reset (reset),
		.i_load  (done_load),
		.i_data  (result),
		.o_valid (o_ls_done_valid),
		.o_data  (o_ls_rdata),
		.i_ready (i_ls_done_ready)
	);

endmodule

//--- rtl/result_hold.sv
`timescale 1ns/1ps

module result_hold #(
	parameter type payload_t = logic
) (
	input  logic     i_clock,
	input  logic     i_reset,
	input  logic     i_load,
	input  payload_t i_data,
	output logic     o_valid,
	output payload_t o_data,
	input  logic     i_ready
);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_valid <= 1'b0;
		end else if (i_load) begin
			o_valid <= 1'b1; // new result wins over a take
		end else if (i_ready) begin
			o_valid <= 1'b0;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_load) begin
			o_data <= i_data;
		end
	end

endmodule

//--- testbench/core_mem_assertions.sv
`timescale 1ns/1ps

module core_mem_assertions (
	input logic                    i_clock,
	input logic                    i_reset,
	input logic                    i_bus_valid,
	input logic                    i_bus_ready,
	input core_mem_pkg::xlen_t     i_bus_addr,
	input core_mem_pkg::bus_size_t i_bus_size,
	input logic                    i_bus_write,
	input core_mem_pkg::xlen_t     i_bus_wdata,
	input core_mem_pkg::wmask_t    i_bus_wmask,
	input logic                    i_bus_id
);

	int failures = 0;

	// request fields stay put until the bus takes them
	bus_stable: assert property (@(posedge i_clock) disable iff (i_reset)
		i_bus_valid && !i_bus_ready |=> i_bus_valid && $stable(i_bus_addr)
		&& $stable(i_bus_size) && $stable(i_bus_write) && $stable(i_bus_wdata)
		&& $stable(i_bus_wmask) && $stable(i_bus_id))
		else begin
			$error("bus request changed before i_bus_ready");
			failures++;
		end

	bus_idle_after_reset: assert property (@(posedge i_clock) i_reset |=> !i_bus_valid)
		else begin
			$error("o_bus_valid high after reset");
			failures++;
		end

	// a finished transaction leaves one idle cycle before the next grant
	single_outstanding: assert property (@(posedge i_clock) disable iff (i_reset)
		i_bus_valid && i_bus_ready |=> !i_bus_valid)
		else begin
			$error("new grant while a transaction was outstanding");
			failures++;
		end

endmodule

bind bus_arbiter core_mem_assertions core_mem_assertions_i (
	.i_clock     (clock),
	.i_reset     (reset),
	.i_bus_valid (o_bus_valid),
	.i_bus_ready (i_bus_ready),
	.i_bus_addr  (o_bus_addr),
	.i_bus_size  (o_bus_size),
	.i_bus_write (o_bus_write),
	.i_bus_wdata (o_bus_wdata),
	.i_bus_wmask (o_bus_wmask),
	.i_bus_id    (o_bus_id)
);

//--- testbench/core_mem_stim.txt
// op addr wdata func3 mask expected, all hex
// op 0 fetch count, 1 redirect, 2 load, 3 store, 4 irq check, 5 mtime wait, 6 random ready
0 6 0 0 00 0
1 80000104 0 0 00 0
0 4 0 0 00 0
3 1000 1122334455667788 3 ff 1122334455667788
3 1003 ab 0 08 ab000000
3 1006 beef 1 c0 beef000000000000
3 1008 89abcdef 2 0f 89abcdef
3 100c f0000001 2 f0 f000000100000000
2 1000 0 3 00 beef3344ab667788
2 1003 0 0 00 ffffffffffffffab
2 1003 0 4 00 ab
2 1006 0 1 00 ffffffffffffbeef
2 1006 0 5 00 beef
2 1008 0 2 00 ffffffff89abcdef
2 100c 0 6 00 f0000001
2 1004 0 2 00 ffffffffbeef3344
2 1001 0 0 00 77
4 0 0 0 00 0
3 2004000 180 3 00 0
5 0 0 0 00 180
4 0 0 0 00 1
6 1 0 0 00 0
1 80002004 0 0 00 0
3 1015 a5 0 20 0000a50000000000
0 5 0 0 00 0
2 1015 0 0 00 ffffffffffffffa5
2 1014 0 5 00 a55a
1 80003000 0 0 00 0
2 1000 0 3 00 beef3344ab667788
0 6 0 0 00 0
6 0 0 0 00 0

//--- testbench/core_mem_tb.sv
`timescale 1ns/1ps
`include "core_mem_consts.svh"

module core_mem_tb;

	localparam int STIM_MAX = 64;
	localparam int COLS = 6;

	logic clock;
	logic reset;
	logic i_redirect;
	core_mem_pkg::xlen_t i_redirect_pc;
	logic o_fetch_valid;
	core_mem_pkg::xlen_t o_fetch_pc;
	core_mem_pkg::instr_t o_fetch_instr;
	logic i_fetch_ready;
	logic i_ls_valid;
	logic o_ls_ready;
	core_mem_pkg::xlen_t i_ls_addr;
	core_mem_pkg::xlen_t i_ls_wdata;
	core_mem_pkg::ls_func3_t i_ls_func3;
	logic i_ls_load;
	logic i_ls_store;
	logic o_ls_done_valid;
	core_mem_pkg::xlen_t o_ls_rdata;
	logic i_ls_done_ready;
	logic o_bus_valid;
	logic i_bus_ready;
	core_mem_pkg::xlen_t o_bus_addr;
	core_mem_pkg::bus_size_t o_bus_size;
	logic o_bus_write;
	core_mem_pkg::xlen_t o_bus_wdata;
	core_mem_pkg::wmask_t o_bus_wmask;
	logic o_bus_id;
	core_mem_pkg::xlen_t i_bus_rdata;
	logic i_bus_ret_id;
	logic o_timer_irq;

	logic [63:0] stim [0:STIM_MAX*COLS-1];
	core_mem_pkg::xlen_t mem [core_mem_pkg::xlen_t]; // sparse bus memory
	core_mem_pkg::wmask_t exp_mask_q [$];
	core_mem_pkg::xlen_t exp_wdata_q [$];
	core_mem_pkg::bus_size_t exp_size;
	core_mem_pkg::xlen_t exp_pc;
	core_mem_pkg::xlen_t redir_pc;
	logic redir_req;
	logic random_mode;
	int fetch_count;
	int mem_txn_count;
	int cycle_count;
	int timeout_limit;

	tb_clock_gen tb_clock_gen_i (
		.o_clock (clock),
		.o_reset (reset)
	);

	core_mem_top core_mem_top_i (.*);

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_fetch(input core_mem_pkg::fetch_packet_t exp,
		input core_mem_pkg::fetch_packet_t got);
		if (exp.pc !== got.pc)
			report_failure($sformatf("FAIL %0t o_fetch_pc exp %h got %h", $time, exp.pc, got.pc));
		if (exp.instr !== got.instr)
			report_failure($sformatf("FAIL %0t o_fetch_instr exp %h got %h",
				$time, exp.instr, got.instr));
	endtask

	task automatic check_load(input core_mem_pkg::xlen_t exp, input core_mem_pkg::xlen_t got);
		if (exp !== got)
			report_failure($sformatf("FAIL %0t o_ls_rdata exp %h got %h", $time, exp, got));
	endtask

	task automatic check_bus_write(input core_mem_pkg::wmask_t exp_mask,
		input core_mem_pkg::xlen_t exp_data, input core_mem_pkg::wmask_t got_mask,
		input core_mem_pkg::xlen_t got_data);
		if (exp_mask !== got_mask)
			report_failure($sformatf("FAIL %0t o_bus_wmask exp %h got %h",
				$time, exp_mask, got_mask));
		if (exp_data !== got_data)
			report_failure($sformatf("FAIL %0t o_bus_wdata exp %h got %h",
				$time, exp_data, got_data));
	endtask

	task automatic check_bus_size(input core_mem_pkg::bus_size_t exp,
		input core_mem_pkg::bus_size_t got);
		if (exp !== got)
			report_failure($sformatf("FAIL %0t o_bus_size exp %0d got %0d", $time, exp, got));
	endtask

	task automatic check_irq(input logic exp, input logic got);
		if (exp !== got)
			report_failure($sformatf("FAIL %0t o_timer_irq exp %b got %b", $time, exp, got));
	endtask

	// unwritten words read back as their own address xor a pattern
	function automatic core_mem_pkg::xlen_t memory_word(input core_mem_pkg::xlen_t addr);
		if (mem.exists(addr))
			return mem[addr];
		return addr ^ 64'h5a5a_5a5a_5a5a_5a5a;
	endfunction

	function automatic core_mem_pkg::instr_t expected_instr(input core_mem_pkg::xlen_t pc);
		core_mem_pkg::xlen_t word;
		word = memory_word({pc[63:3], 3'b000});
		return pc[2] ? word[63:32] : word[31:0];
	endfunction

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (timeout_limit != 0 && cycle_count > timeout_limit)
			report_failure("timeout, the test did not finish within the cycle limit");
	end

	// bus memory model
	initial begin
		int wait_cycles;
		logic pending;
		core_mem_pkg::xlen_t old_word;
		core_mem_pkg::xlen_t lane_mask;
		i_bus_ready = 1'b0;
		i_bus_rdata = '0;
		i_bus_ret_id = 1'b0;
		pending = 1'b0;
		wait_cycles = 0;
		forever begin
			@(posedge clock);
			#1;
			i_bus_ready = 1'b0;
			if (!reset && o_bus_valid) begin
				if (!pending) begin
					wait_cycles = $urandom % 4;
					pending = 1'b1;
				end
				if (wait_cycles == 0) begin
					pending = 1'b0;
					i_bus_rdata = memory_word(o_bus_addr);
					i_bus_ret_id = o_bus_id;
					i_bus_ready = 1'b1;
					if (o_bus_id == `CM_ID_MEM) begin
						mem_txn_count++;
						check_bus_size(exp_size, o_bus_size);
					end else begin
						check_bus_size(core_mem_pkg::SIZE_WORD, o_bus_size);
					end
					if (o_bus_write) begin
						if (exp_mask_q.size() == 0)
							report_failure("a bus write appeared that no store asked for");
						check_bus_write(exp_mask_q.pop_front(), exp_wdata_q.pop_front(),
							o_bus_wmask, o_bus_wdata);
						old_word = memory_word(o_bus_addr);
						for (int b = 0; b < 8; b++)
							lane_mask[b*8 +: 8] = {8{o_bus_wmask[b]}};
						mem[o_bus_addr] = (old_word & ~lane_mask) | (o_bus_wdata & lane_mask);
					end
				end else begin
					wait_cycles--;
				end
			end
		end
	end

	// fetch consumer, also performs redirects
	initial begin
		i_fetch_ready = 1'b0;
		i_redirect = 1'b0;
		i_redirect_pc = '0;
		@(negedge reset);
		forever begin
			@(posedge clock);
			#1;
			if (redir_req && !i_redirect) begin
				i_redirect = 1'b1;
				i_redirect_pc = redir_pc;
				i_fetch_ready = 1'b0; // no packet taken in the redirect cycle
				exp_pc = redir_pc;
			end else begin
				if (i_redirect)
					redir_req = 1'b0;
				i_redirect = 1'b0;
				i_fetch_ready = random_mode ? 1'($urandom % 2) : 1'b1;
			end
		end
	end

	always @(negedge clock) begin
		core_mem_pkg::fetch_packet_t exp_pkt;
		core_mem_pkg::fetch_packet_t got_pkt;
		if (!reset && o_fetch_valid && i_fetch_ready) begin
			exp_pkt.pc = exp_pc;
			exp_pkt.instr = expected_instr(exp_pc);
			got_pkt.pc = o_fetch_pc;
			got_pkt.instr = o_fetch_instr;
			check_fetch(exp_pkt, got_pkt);
			exp_pc = exp_pc + 4;
			fetch_count++;
		end
	end

	initial begin
		i_ls_done_ready = 1'b0;
		@(negedge reset);
		forever begin
			@(posedge clock);
			#1 i_ls_done_ready = random_mode ? 1'($urandom % 2) : 1'b1;
		end
	end

	task automatic run_ls(input logic is_store, input core_mem_pkg::xlen_t addr,
		input core_mem_pkg::xlen_t wdata, input core_mem_pkg::ls_func3_t func3,
		output core_mem_pkg::xlen_t rdata);
		logic is_timer;
		int txn_before;
		is_timer = (addr == `CM_MTIMECMP_ADDR) || (addr == `CM_MTIME_ADDR);
		txn_before = mem_txn_count;
		exp_size = core_mem_pkg::bus_size_t'(func3[1:0]);
		@(posedge clock);
		#1;
		i_ls_valid = 1'b1;
		i_ls_addr = addr;
		i_ls_wdata = wdata;
		i_ls_func3 = func3;
		i_ls_load = !is_store;
		i_ls_store = is_store;
		do @(negedge clock); while (!o_ls_ready);
		@(posedge clock);
		#1 i_ls_valid = 1'b0;
		do @(negedge clock); while (!(o_ls_done_valid && i_ls_done_ready));
		rdata = o_ls_rdata;
		if (is_timer && mem_txn_count != txn_before)
			report_failure("a timer access went out on the bus");
		if (is_store && exp_mask_q.size() != 0)
			report_failure("a store finished without its bus write");
	endtask

	initial begin
		int n_lines;
		logic [63:0] op;
		logic [63:0] addr;
		logic [63:0] wdata;
		logic [63:0] func3;
		logic [63:0] mask;
		logic [63:0] expected;
		core_mem_pkg::xlen_t rdata;
		void'($urandom(74324));
		cycle_count = 0;
		timeout_limit = 0;
		fetch_count = 0;
		mem_txn_count = 0;
		exp_size = core_mem_pkg::SIZE_BYTE;
		exp_pc = `CM_RESET_PC;
		redir_pc = '0;
		redir_req = 1'b0;
		random_mode = 1'b0;
		i_ls_valid = 1'b0;
		i_ls_addr = '0;
		i_ls_wdata = '0;
		i_ls_func3 = '0;
		i_ls_load = 1'b0;
		i_ls_store = 1'b0;
		$readmemh("testbench/core_mem_stim.txt", stim);
		n_lines = 0;
		while (n_lines < STIM_MAX && !$isunknown(stim[n_lines*COLS]))
			n_lines++;
		timeout_limit = 40 * n_lines + 100;
		@(negedge reset);
		for (int i = 0; i < n_lines; i++) begin
			op = stim[i*COLS];
			addr = stim[i*COLS+1];
			wdata = stim[i*COLS+2];
			func3 = stim[i*COLS+3];
			mask = stim[i*COLS+4];
			expected = stim[i*COLS+5];
			case (op)
				0: begin
					int target;
					target = fetch_count + int'(addr);
					wait (fetch_count >= target);
				end
				1: begin
					redir_pc = addr;
					redir_req = 1'b1;
					wait (redir_req == 1'b0);
				end
				2: begin
					run_ls(1'b0, addr, '0, func3[2:0], rdata);
					check_load(expected, rdata);
				end
				3: begin
					if (addr != `CM_MTIMECMP_ADDR && addr != `CM_MTIME_ADDR) begin
						exp_mask_q.push_back(mask[7:0]);
						exp_wdata_q.push_back(expected);
					end
					run_ls(1'b1, addr, wdata, func3[2:0], rdata);
					check_load('0, rdata); // stores report zero
				end
				4: begin
					@(negedge clock);
					check_irq(expected[0], o_timer_irq);
				end
				5: begin
					do run_ls(1'b0, `CM_MTIME_ADDR, '0, 3'd3, rdata);
					while (rdata < expected);
					@(negedge clock);
					check_irq(1'b1, o_timer_irq);
				end
				6: random_mode = addr[0];
				default: report_failure($sformatf("unknown operation in stim line %0d", i));
			endcase
		end
		if (core_mem_top_i.bus_arbiter_i.core_mem_assertions_i.failures != 0) begin
			report_failure("a bus assertion in the bound checker failed");
		end else begin
			$display("ALL TESTS PASSED");
			$finish;
		end
	end

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter realtime PERIOD = 100.0,
	parameter int RESET_CYCLES = 8
) (
	output logic o_clock,
	output logic o_reset
);

	initial begin
		o_clock = 1'b0;
		forever #(PERIOD / 2) o_clock = ~o_clock;
	end

	initial begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clock);
		#1 o_reset = 1'b0; // released with the other inputs
	end

endmodule
